/* alu_cluster.f */
+incdir+include
hdl/alu_pkg.sv
hdl/cond_issue.sv
hdl/alu_lane.sv
hdl/result_collect.sv
hdl/alu_cluster.sv
sim/alu_cluster_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the alu_cluster testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary -j 0 --top-module alu_cluster_tb -f alu_cluster.f -o alu_cluster_sim

./obj_dir/alu_cluster_sim | tee "$LOG"

if grep -q "^TESTS PASSED$" "$LOG"; then
  echo "simulation passed"
else
  echo "simulation failed, see $LOG"
  exit 1
fi

/* sim/alu_cluster_tb.sv */
// ======================================================================
// random stimulus uses a fixed seed; expects the fixed cluster latency,
// every valid group is checked when it leaves the pipeline
// ======================================================================
`timescale 1ns/1ns
`default_nettype none
`include "alu_cluster_cfg.svh"

module alu_cluster_tb
  import alu_pkg::*;
;

  localparam int MSB         = `ALU_DATA_W - 1;
  localparam int RST_CYCLES  = 5;
  localparam int IDLE_CYCLES = 4;
  localparam int N_DIRECTED  = 7;
  localparam int N_COND      = 16 * 16 / `ALU_LANES;
  localparam int N_EN        = 16;
  localparam int N_RAND      = 2000;
  localparam int N_GROUPS    = IDLE_CYCLES + N_DIRECTED + N_COND + N_EN + N_RAND;
  localparam int TIMEOUT     = N_GROUPS + RST_CYCLES + 20;
  localparam word_t SHIFT_A  = 64'hC000_0001_8000_0003;

  logic                         clk;
  logic                         rst;
  logic                         grp_valid;
  lane_mask_t                   op_en;
  alu_op_t [`ALU_LANES-1:0]     op;
  cond_t   [`ALU_LANES-1:0]     cond;
  word_t   [`ALU_LANES-1:0]     a;
  word_t   [`ALU_LANES-1:0]     b;
  flags_t                       flags_in;
  logic                         out_valid;
  lane_mask_t                   exec_mask;
  word_t   [`ALU_LANES-1:0]     result;
  flags_t  [`ALU_LANES-1:0]     lane_flags;
  flags_t                       grp_flags;

  // staged lane values for the next drive_cycle
  alu_op_t [`ALU_LANES-1:0]     s_op;
  cond_t   [`ALU_LANES-1:0]     s_cond;
  word_t   [`ALU_LANES-1:0]     s_a;
  word_t   [`ALU_LANES-1:0]     s_b;

  // expected groups in entry order
  int                           q_due [$];
  lane_mask_t                   q_mask [$];
  word_t   [`ALU_LANES-1:0]     q_res [$];
  flags_t  [`ALU_LANES-1:0]     q_lf [$];
  flags_t                       q_gf [$];

  int                           cycle = 0;
  integer                       seed;
  logic [31:0]                  rnd;

  alu_cluster dut (
    .clk(clk), .rst(rst),
    .grp_valid(grp_valid), .op_en(op_en), .op(op), .cond(cond),
    .a(a), .b(b), .flags_in(flags_in),
    .out_valid(out_valid), .exec_mask(exec_mask),
    .result(result), .lane_flags(lane_flags), .grp_flags(grp_flags)
  );

  always #5 clk = ~clk;

  // returns {carry, overflow, negative, zero, result}
  function automatic logic [67:0] ref_alu(input alu_op_t o, input word_t x, input word_t y);
    logic [64:0] sum;
    logic [5:0]  sh;
    word_t       r;
    logic        c;
    logic        v;
    sh = y[5:0];
    c  = 1'b0;
    v  = 1'b0;
    case (o)
      OP_ADD: begin
        sum = {1'b0, x} + {1'b0, y};
        r   = sum[MSB:0];
        c   = sum[64];
        v   = (x[MSB] == y[MSB]) && (r[MSB] != x[MSB]);
      end
      OP_SUB: begin
        r = x - y;
        c = (x >= y);  // no borrow
        v = (x[MSB] != y[MSB]) && (r[MSB] != x[MSB]);
      end
      OP_AND: r = x & y;
      OP_XOR: r = x ^ y;
      OP_OR:  r = x | y;
      OP_SHL: r = x << sh;
      OP_SHR: r = x >> sh;
      OP_SAR: r = $signed(x) >>> sh;
      OP_SXT: begin
        case (y[1:0])
          2'd0:    r = {{(`ALU_DATA_W-8){x[7]}}, x[7:0]};
          2'd1:    r = {{(`ALU_DATA_W-16){x[15]}}, x[15:0]};
          2'd2:    r = {{(`ALU_DATA_W-32){x[31]}}, x[31:0]};
          default: r = x;
        endcase
      end
      default: r = '0;
    endcase
    return {c, v, r[MSB], (r == '0), r};
  endfunction

  function automatic logic cond_ok(input cond_t c, input flags_t f);
    logic ok;
    case (c)
      EQ:      ok = f[FL_Z];
      NE:      ok = !f[FL_Z];
      CS:      ok = f[FL_C];
      CC:      ok = !f[FL_C];
      MI:      ok = f[FL_N];
      PL:      ok = !f[FL_N];
      VS:      ok = f[FL_V];
      VC:      ok = !f[FL_V];
      HI:      ok = f[FL_C] && !f[FL_Z];
      LS:      ok = !f[FL_C] || f[FL_Z];
      GE:      ok = (f[FL_N] == f[FL_V]);
      LT:      ok = (f[FL_N] != f[FL_V]);
      GT:      ok = !f[FL_Z] && (f[FL_N] == f[FL_V]);
      LE:      ok = f[FL_Z] || (f[FL_N] != f[FL_V]);
      AL:      ok = 1'b1;
      default: ok = 1'b0;  // NV
    endcase
    return ok;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string field, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, field, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "run stopped");
    end
  endtask

  task automatic set_lane(input int i, input alu_op_t o, input word_t x, input word_t y,
                          input cond_t c);
    s_op[i]   = o;
    s_a[i]    = x;
    s_b[i]    = y;
    s_cond[i] = c;
  endtask

  // one rising edge; a valid group also queues its expected outputs
  task automatic drive_cycle(input logic v, input lane_mask_t en, input flags_t fl);
    logic [67:0]             r;
    lane_mask_t              ex;
    word_t  [`ALU_LANES-1:0] er;
    flags_t [`ALU_LANES-1:0] ef;
    flags_t                  gf;
    @(posedge clk);
    if (v) begin
      gf = fl;
      for (int i = 0; i < `ALU_LANES; i++) begin
        ex[i] = en[i] && cond_ok(s_cond[i], fl);
        if (ex[i]) begin
          r     = ref_alu(s_op[i], s_a[i], s_b[i]);
          er[i] = r[MSB:0];
          ef[i] = r[67:64];
          gf    = ef[i];  // higher lanes override
        end else begin
          er[i] = '0;
          ef[i] = '0;
        end
      end
      q_due.push_back(cycle + 5);  // cycle still holds the count before this edge
      q_mask.push_back(ex);
      q_res.push_back(er);
      q_lf.push_back(ef);
      q_gf.push_back(gf);
    end
    grp_valid <= v;
    op_en     <= en;
    op        <= s_op;
    cond      <= s_cond;
    a         <= s_a;
    b         <= s_b;
    flags_in  <= fl;
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT) abort_run("timeout: the run did not finish in time");
  end

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      if (q_due.size() != 0 && q_due[0] == cycle) begin
        if (out_valid !== 1'b1) begin
          abort_run("a group was due on the outputs but out_valid was low");
        end else begin
          check_value("exec_mask", 64'(exec_mask), 64'(q_mask[0]));
          for (int i = 0; i < `ALU_LANES; i++) begin
            check_value($sformatf("result[%0d]", i), result[i], q_res[0][i]);
            check_value($sformatf("lane_flags[%0d]", i), 64'(lane_flags[i]), 64'(q_lf[0][i]));
          end
          check_value("grp_flags", 64'(grp_flags), 64'(q_gf[0]));
          void'(q_due.pop_front());
          void'(q_mask.pop_front());
          void'(q_res.pop_front());
          void'(q_lf.pop_front());
          void'(q_gf.pop_front());
        end
      end else if (out_valid !== 1'b0) begin
        abort_run("out_valid was high while no group was due");
      end else begin
        check_value("idle exec_mask", 64'(exec_mask), 64'd0);
      end
    end
  end

  initial begin
    seed      = 32'ha1c4_fb6c;
    clk       = 1'b0;
    rst       = 1'b1;
    grp_valid = 1'b0;
    op_en     = '0;
    flags_in  = '0;
    for (int i = 0; i < `ALU_LANES; i++) begin
      set_lane(i, OP_ADD, '0, '0, AL);
      op[i]   = OP_ADD;
      cond[i] = AL;
      a[i]    = '0;
      b[i]    = '0;
    end
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;

    repeat (IDLE_CYCLES) drive_cycle(1'b0, '0, '0);

    // add and sub across the half boundary
    set_lane(0, OP_ADD, 64'h0000_0000_FFFF_FFFF, 64'd1, AL);
    set_lane(1, OP_ADD, 64'h7FFF_FFFF_FFFF_FFFF, 64'd1, AL);
    set_lane(2, OP_ADD, 64'hFFFF_FFFF_FFFF_FFFF, 64'd1, AL);
    set_lane(3, OP_ADD, 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000, AL);
    drive_cycle(1'b1, '1, '0);
    set_lane(0, OP_SUB, 64'h0000_0001_0000_0000, 64'd1, AL);
    set_lane(1, OP_SUB, 64'd5, 64'd5, AL);
    set_lane(2, OP_SUB, 64'd0, 64'd1, AL);
    set_lane(3, OP_SUB, 64'h8000_0000_0000_0000, 64'd1, AL);
    drive_cycle(1'b1, '1, '0);

    set_lane(0, OP_AND, 64'hF0F0_FFFF_0000_1234, 64'h0FF0_00FF_FFFF_FF00, AL);
    set_lane(1, OP_XOR, 64'hA5A5_A5A5_5A5A_5A5A, 64'hA5A5_A5A5_5A5A_5A5A, AL);
    set_lane(2, OP_OR,  64'h8000_0000_0000_0000, 64'h0000_0000_0000_0001, AL);
    set_lane(3, OP_SUB, 64'h1234_0000_0000_0000, 64'h0000_0000_0000_0001, AL);
    drive_cycle(1'b1, '1, '0);

    // bit 8 of b is set and must be ignored by the shifts
    for (int s = 0; s < 3; s++) begin
      set_lane(0, alu_op_t'(4'(int'(OP_SHL) + s)), SHIFT_A, 64'h100, AL);
      set_lane(1, alu_op_t'(4'(int'(OP_SHL) + s)), SHIFT_A, 64'h11F, AL);
      set_lane(2, alu_op_t'(4'(int'(OP_SHL) + s)), SHIFT_A, 64'h120, AL);
      set_lane(3, alu_op_t'(4'(int'(OP_SHL) + s)), SHIFT_A, 64'h13F, AL);
      drive_cycle(1'b1, '1, '0);
    end

    for (int i = 0; i < `ALU_LANES; i++) begin
      set_lane(i, OP_SXT, 64'h1234_5678_9ABC_DEF0, 64'(i), AL);
    end
    drive_cycle(1'b1, '1, '0);

    // every condition code against every flags value
    for (int f = 0; f < 16; f++) begin
      for (int g = 0; g < 16 / `ALU_LANES; g++) begin
        for (int i = 0; i < `ALU_LANES; i++) begin
          set_lane(i, OP_ADD, 64'(f * 16 + i), 64'(g + 1), cond_t'(4'(g * `ALU_LANES + i)));
        end
        drive_cycle(1'b1, '1, flags_t'(f));
      end
    end

    // op_en patterns where a zero mask falls back to flags_in
    for (int f = 0; f < N_EN; f++) begin
      for (int i = 0; i < `ALU_LANES; i++) begin
        set_lane(i, alu_op_t'(4'((f + i) % 9)), 64'(f * 3 + 1), 64'(i + 2), AL);
      end
      drive_cycle(1'b1, lane_mask_t'(f), flags_t'(15 - f));
    end

    for (int n = 0; n < N_RAND; n++) begin
      for (int i = 0; i < `ALU_LANES; i++) begin
        rnd       = $random(seed);
        s_op[i]   = alu_op_t'(4'(rnd[31:16] % 16'd9));
        s_cond[i] = cond_t'(rnd[7:4]);
        s_a[i]    = {$random(seed), $random(seed)};
        s_b[i]    = rnd[8] ? s_a[i] : {$random(seed), $random(seed)};
      end
      rnd = $random(seed);
      drive_cycle((rnd % 5) != 0, lane_mask_t'(rnd >> 8), flags_t'(rnd >> 12));
    end

    drive_cycle(1'b0, '0, '0);
    repeat (8) @(posedge clk);
    if (q_due.size() != 0) begin
      $display("%0d groups never appeared on the outputs", q_due.size());
      $display("TESTS FAILED");
      $fatal(1, "run stopped");
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* hdl/alu_cluster.sv */
// ======================================================================
// fixed 4-cycle latency from input edge to outputs, full throughput,
// no back-pressure so every out_valid must be consumed
// ======================================================================
`timescale 1ns/1ns
`default_nettype none
`include "alu_cluster_cfg.svh"

module alu_cluster
  import alu_pkg::*;
(
  input  wire                            clk,
  input  wire                            rst,
  input  wire                            grp_valid,
  input  wire lane_mask_t                op_en,
  input  wire alu_op_t [`ALU_LANES-1:0]  op,
  input  wire cond_t   [`ALU_LANES-1:0]  cond,
  input  wire word_t   [`ALU_LANES-1:0]  a,
  input  wire word_t   [`ALU_LANES-1:0]  b,
  input  wire flags_t                    flags_in,
  output wire                            out_valid,
  output wire lane_mask_t                exec_mask,
  output wire word_t   [`ALU_LANES-1:0]  result,
  output wire flags_t  [`ALU_LANES-1:0]  lane_flags,
  output wire flags_t                    grp_flags
);

  wire lane_mask_t               issue_valid;
  wire alu_op_t [`ALU_LANES-1:0] issue_op;
  wire word_t   [`ALU_LANES-1:0] issue_a;
  wire word_t   [`ALU_LANES-1:0] issue_b;
  wire                           tok_valid;
  wire lane_mask_t               tok_mask;
  wire flags_t                   tok_flags;
  wire lane_mask_t               done;
  wire word_t   [`ALU_LANES-1:0] res;
  wire flags_t  [`ALU_LANES-1:0] res_flags;

  cond_issue u_issue (
    .clk(clk), .rst(rst),
    .grp_valid(grp_valid), .op_en(op_en), .op(op), .cond(cond),
    .a(a), .b(b), .flags_in(flags_in),
    .issue_valid(issue_valid), .issue_op(issue_op),
    .issue_a(issue_a), .issue_b(issue_b),
    .tok_valid(tok_valid), .tok_mask(tok_mask), .tok_flags(tok_flags)
  );

  for (genvar i = 0; i < `ALU_LANES; i++) begin : g_lane
    alu_lane u_lane (
      .clk(clk), .rst(rst),
      .issue_valid(issue_valid[i]), .issue_op(issue_op[i]),
      .issue_a(issue_a[i]), .issue_b(issue_b[i]),
      .done(done[i]), .res(res[i]), .res_flags(res_flags[i])
    );
  end

  result_collect u_collect (
    .clk(clk), .rst(rst),
    .done(done), .res(res), .res_flags(res_flags),
    .tok_valid(tok_valid), .tok_mask(tok_mask), .tok_flags(tok_flags),
    .out_valid(out_valid), .exec_mask(exec_mask),
    .result(result), .lane_flags(lane_flags), .grp_flags(grp_flags)
  );

endmodule

`default_nettype wire

/* hdl/result_collect.sv */
// ======================================================================
// outputs every group, no back-pressure; idle lanes read zero result
// and zero flags, grp_flags falls back to the group's flags_in
// ======================================================================
`timescale 1ns/1ns
`default_nettype none
`include "alu_cluster_cfg.svh"

module result_collect
  import alu_pkg::*;
(
  input  wire                           clk,
  input  wire                           rst,
  input  wire lane_mask_t               done,
  input  wire word_t  [`ALU_LANES-1:0]  res,
  input  wire flags_t [`ALU_LANES-1:0]  res_flags,
  input  wire                           tok_valid,
  input  wire lane_mask_t               tok_mask,
  input  wire flags_t                   tok_flags,
  output logic                          out_valid,
  output lane_mask_t                    exec_mask,
  output word_t       [`ALU_LANES-1:0]  result,
  output flags_t      [`ALU_LANES-1:0]  lane_flags,
  output flags_t                        grp_flags
);

  // token delay matching the two lane stages
  logic       t1_valid;
  lane_mask_t t1_mask;
  flags_t     t1_flags;
  logic       t2_valid;
  lane_mask_t t2_mask;
  flags_t     t2_flags;

  flags_t     grp_sel;

  always_comb begin
    grp_sel = t2_flags;
    for (int i = 0; i < `ALU_LANES; i++) begin
      if (done[i]) grp_sel = res_flags[i];  // highest lane wins
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      t1_valid  <= 1'b0;
      t1_mask   <= '0;
      t2_valid  <= 1'b0;
      t2_mask   <= '0;
      out_valid <= 1'b0;
      exec_mask <= '0;
    end else begin
      t1_valid  <= tok_valid;
      t1_mask   <= tok_mask;
      t2_valid  <= t1_valid;
      t2_mask   <= t1_mask;
      out_valid <= t2_valid;
      exec_mask <= t2_mask;
    end
  end

  always_ff @(posedge clk) begin
    t1_flags  <= tok_flags;
    t2_flags  <= t1_flags;
    grp_flags <= grp_sel;
    for (int i = 0; i < `ALU_LANES; i++) begin
      result[i]     <= done[i] ? res[i] : '0;
      lane_flags[i] <= done[i] ? res_flags[i] : '0;
    end
  end

endmodule

`default_nettype wire

/* hdl/alu_lane.sv */
// ======================================================================
// two cycles from issue_valid to done, low half first, then high half
// and flags; carry/overflow are only meaningful for add and sub
// ======================================================================
`timescale 1ns/1ns
`default_nettype none
`include "alu_cluster_cfg.svh"

module alu_lane
  import alu_pkg::*;
(
  input  wire          clk,
  input  wire          rst,
  input  wire          issue_valid,
  input  wire alu_op_t issue_op,
  input  wire word_t   issue_a,
  input  wire word_t   issue_b,
  output logic         done,
  output word_t        res,
  output flags_t       res_flags
);

  localparam int HW  = `ALU_HALF_W;
  localparam int MSB = `ALU_DATA_W - 1;

  // full-width shift and sign-extend result for both stages
  function automatic word_t shift_sxt(input alu_op_t o, input word_t x, input word_t y);
    logic [5:0] sh;
    word_t r;
    sh = y[5:0];
    case (o)
      OP_SHL: r = x << sh;
      OP_SHR: r = x >> sh;
      OP_SAR: r = word_t'($signed(x) >>> sh);
      OP_SXT: begin
        case (y[1:0])
          2'd0:    r = {{(`ALU_DATA_W-8){x[7]}}, x[7:0]};
          2'd1:    r = {{(`ALU_DATA_W-16){x[15]}}, x[15:0]};
          2'd2:    r = {{(`ALU_DATA_W-32){x[31]}}, x[31:0]};
          default: r = x;
        endcase
      end
      default: r = '0;
    endcase
    return r;
  endfunction

  function automatic half_t logic_half(input alu_op_t o, input half_t x, input half_t y);
    half_t r;
    case (o)
      OP_AND:  r = x & y;
      OP_XOR:  r = x ^ y;
      OP_OR:   r = x | y;
      default: r = '0;
    endcase
    return r;
  endfunction

  // sub is x + ~y + cin with cin set in the low half
  function automatic logic [HW:0] addsub_half(input logic sub, input half_t x, input half_t y,
                                              input logic cin);
    half_t yx;
    yx = sub ? ~y : y;
    return {1'b0, x} + {1'b0, yx} + {{HW{1'b0}}, cin};
  endfunction

  half_t       lo_calc;
  logic        is_sub;
  logic [HW:0] lo_sum;
  word_t       full_in;

  logic        s1_valid;
  alu_op_t     s1_op;
  word_t       s1_a;
  word_t       s1_b;
  half_t       s1_lo;
  logic        s1_c;     // carry into the high half

  half_t       hi_calc;
  logic        s1_sub;
  logic [HW:0] hi_sum;
  word_t       full_s1;
  word_t       res_next;
  flags_t      flags_next;

  assign is_sub  = (issue_op == OP_SUB);
  assign lo_sum  = addsub_half(is_sub, issue_a[HW-1:0], issue_b[HW-1:0], is_sub);
  assign full_in = shift_sxt(issue_op, issue_a, issue_b);

  always_comb begin
    case (issue_op)
      OP_ADD, OP_SUB:        lo_calc = lo_sum[HW-1:0];
      OP_AND, OP_XOR, OP_OR: lo_calc = logic_half(issue_op, issue_a[HW-1:0], issue_b[HW-1:0]);
      default:               lo_calc = full_in[HW-1:0];
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) s1_valid <= 1'b0;
    else     s1_valid <= issue_valid;
  end

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      s1_op <= issue_op;
      s1_a  <= issue_a;
      s1_b  <= issue_b;
      s1_lo <= lo_calc;
      s1_c  <= lo_sum[HW];
    end
  end

  assign s1_sub  = (s1_op == OP_SUB);
  assign hi_sum  = addsub_half(s1_sub, s1_a[MSB:HW], s1_b[MSB:HW], s1_c);
  assign full_s1 = shift_sxt(s1_op, s1_a, s1_b);

  always_comb begin
    case (s1_op)
      OP_ADD, OP_SUB:        hi_calc = hi_sum[HW-1:0];
      OP_AND, OP_XOR, OP_OR: hi_calc = logic_half(s1_op, s1_a[MSB:HW], s1_b[MSB:HW]);
      default:               hi_calc = full_s1[MSB:HW];
    endcase
  end

  assign res_next = {hi_calc, s1_lo};

  always_comb begin
    flags_next       = '0;
    flags_next[FL_Z] = (res_next == '0);
    flags_next[FL_N] = res_next[MSB];
    if (s1_op == OP_ADD) begin
      flags_next[FL_C] = hi_sum[HW];
      flags_next[FL_V] = (s1_a[MSB] == s1_b[MSB]) && (res_next[MSB] != s1_a[MSB]);
    end else if (s1_sub) begin
      flags_next[FL_C] = hi_sum[HW];  // set means no borrow
      flags_next[FL_V] = (s1_a[MSB] != s1_b[MSB]) && (res_next[MSB] != s1_a[MSB]);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) done <= 1'b0;
    else     done <= s1_valid;
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      res       <= res_next;
      res_flags <= flags_next;
    end
  end

endmodule

`default_nettype wire

/* hdl/cond_issue.sv */
// ======================================================================
// one issue group per clock, no stall; operands held only for lanes
// whose op_en is set and whose condition passes on flags_in
// ======================================================================
`timescale 1ns/1ns
`default_nettype none
`include "alu_cluster_cfg.svh"

module cond_issue
  import alu_pkg::*;
(
  input  wire                            clk,
  input  wire                            rst,
  input  wire                            grp_valid,
  input  wire lane_mask_t                op_en,
  input  wire alu_op_t [`ALU_LANES-1:0]  op,
  input  wire cond_t   [`ALU_LANES-1:0]  cond,
  input  wire word_t   [`ALU_LANES-1:0]  a,
  input  wire word_t   [`ALU_LANES-1:0]  b,
  input  wire flags_t                    flags_in,
  output lane_mask_t                     issue_valid,
  output alu_op_t      [`ALU_LANES-1:0]  issue_op,
  output word_t        [`ALU_LANES-1:0]  issue_a,
  output word_t        [`ALU_LANES-1:0]  issue_b,
  output logic                           tok_valid,
  output lane_mask_t                     tok_mask,
  output flags_t                         tok_flags
);

  lane_mask_t pass;

  function automatic logic cond_pass(input cond_t c, input flags_t f);
    logic cf;
    logic vf;
    logic nf;
    logic zf;
    logic ok;
    cf = f[FL_C];
    vf = f[FL_V];
    nf = f[FL_N];
    zf = f[FL_Z];
    case (c)
      EQ:      ok = zf;
      NE:      ok = ~zf;
      CS:      ok = cf;
      CC:      ok = ~cf;
      MI:      ok = nf;
      PL:      ok = ~nf;
      VS:      ok = vf;
      VC:      ok = ~vf;
      HI:      ok = cf & ~zf;
      LS:      ok = ~cf | zf;
      GE:      ok = (nf == vf);
      LT:      ok = (nf != vf);
      GT:      ok = ~zf & (nf == vf);
      LE:      ok = zf | (nf != vf);
      AL:      ok = 1'b1;
      default: ok = 1'b0;  // NV
    endcase
    return ok;
  endfunction

  always_comb begin
    for (int i = 0; i < `ALU_LANES; i++) begin
      pass[i] = grp_valid & op_en[i] & cond_pass(cond[i], flags_in);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      issue_valid <= '0;
      tok_valid   <= 1'b0;
      tok_mask    <= '0;
    end else begin
      issue_valid <= pass;
      tok_valid   <= grp_valid;
      tok_mask    <= pass;  // lanes that actually execute
    end
  end

  always_ff @(posedge clk) begin
    if (grp_valid) tok_flags <= flags_in;
    for (int i = 0; i < `ALU_LANES; i++) begin
      if (pass[i]) begin
        issue_op[i] <= op[i];
        issue_a[i]  <= a[i];
        issue_b[i]  <= b[i];
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/alu_pkg.sv */
// ======================================================================
// shared types for the cluster, sized from alu_cluster_cfg.svh
// flags_t bit order is carry, overflow, negative, zero (msb first)
// ======================================================================
`default_nettype none

package alu_pkg;

`include "alu_cluster_cfg.svh"

  typedef logic [`ALU_DATA_W-1:0] word_t;
  typedef logic [`ALU_HALF_W-1:0] half_t;
  typedef logic [3:0]             flags_t;
  typedef logic [`ALU_LANES-1:0]  lane_mask_t;

  // bit positions inside flags_t
  localparam int FL_C = 3;
  localparam int FL_V = 2;
  localparam int FL_N = 1;
  localparam int FL_Z = 0;

  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_XOR,
    OP_OR,
    OP_SHL,  // amount in b[5:0]
    OP_SHR,
    OP_SAR,
    OP_SXT   // b[1:0] picks byte, half, word, or pass
  } alu_op_t;

  typedef enum logic [3:0] {
    EQ, NE,
    CS, CC,
    MI, PL,
    VS, VC,
    HI, LS,
    GE, LT,
    GT, LE,
    AL, NV
  } cond_t;

endpackage

`default_nettype wire

/* include/alu_cluster_cfg.svh */
// ======================================================================
// lane count and widths for the integer cluster; ALU_HALF_W must be
// exactly half of ALU_DATA_W, the lanes split their adders there
// ======================================================================
`ifndef ALU_CLUSTER_CFG_SVH
`define ALU_CLUSTER_CFG_SVH

`define ALU_LANES  4
`define ALU_DATA_W 64
`define ALU_HALF_W 32

`endif
